//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tinyrv
FILELIST  ?= tinyrv.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_tinyrv.sv
`timescale 1ns/1ps

module tb_tinyrv;

    localparam int          CODE_WORD      = 64;
    localparam logic [31:0] RESET_PC       = 32'(CODE_WORD * 4);
    localparam int          MEM_WORDS      = 1024;
    localparam logic [31:0] DATA_BASE      = 32'h0000_0600;
    localparam int          DATA_WORDS     = 64;
    localparam logic [31:0] DUMP_BASE      = 32'h0000_0700;
    localparam int          BODY_LEN       = 180;
    localparam int          PROG_MAX       = 320;
    localparam int          TIMEOUT_CYCLES = 20000;

    typedef enum int {
        K_LUI, K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_LW, K_SW, K_BEQ, K_BNE, K_JAL
    } kind_e;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    rv_core_pkg::mem_req_s mem_req;
    rv_core_pkg::word_t    mem_rdata;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] model_mem [0:MEM_WORDS-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    // the model runs the program from these fields
    kind_e       p_kind [0:PROG_MAX-1];
    int          p_rd [0:PROG_MAX-1];
    int          p_rs1 [0:PROG_MAX-1];
    int          p_rs2 [0:PROG_MAX-1];
    logic [31:0] p_imm [0:PROG_MAX-1];

    int          prog_len = 0;
    int          body_end = 0;
    int          halt_idx = 0;
    logic [31:0] halt_pc = '0;
    int          recent [0:3];
    int          errors = 0;
    int          got_stores = 0;
    int          halt_fetches = 0;
    bit          seen_first_req = 1'b0;
    bit          read_pending = 1'b0;
    logic [31:0] read_addr = '0;

    tinyrv_top #(
        .RESET_PC(RESET_PC)
    ) u_dut (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .mem_req_o(mem_req),
        .mem_rdata_i(mem_rdata)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic [31:0] sign_extend12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input int rs2,
                                                input int rs1, input logic [2:0] f3,
                                                input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [31:0] imm, input int rs1,
                                                input logic [2:0] f3, input int rd,
                                                input logic [6:0] opc);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [31:0] imm, input int rs2,
                                                input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type_word(input logic [31:0] imm, input int rs2,
                                                input int rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [31:0] imm, input int rd);
        return {imm[31:12], 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type_word(input logic [31:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(input kind_e k, input int rd, input int rs1, input int rs2,
                        input logic [31:0] imm);
        logic [31:0] word;
        case (k)
            K_LUI:   word = u_type_word(imm, rd);
            K_ADDI:  word = i_type_word(imm, rs1, 3'b000, rd, 7'b0010011);
            K_ADD:   word = r_type_word(7'b0000000, rs2, rs1, 3'b000, rd);
            K_SUB:   word = r_type_word(7'b0100000, rs2, rs1, 3'b000, rd);
            K_SLT:   word = r_type_word(7'b0000000, rs2, rs1, 3'b010, rd);
            K_XOR:   word = r_type_word(7'b0000000, rs2, rs1, 3'b100, rd);
            K_OR:    word = r_type_word(7'b0000000, rs2, rs1, 3'b110, rd);
            K_AND:   word = r_type_word(7'b0000000, rs2, rs1, 3'b111, rd);
            K_LW:    word = i_type_word(imm, rs1, 3'b010, rd, 7'b0000011);
            K_SW:    word = s_type_word(imm, rs2, rs1);
            K_BEQ:   word = b_type_word(imm, rs2, rs1, 3'b000);
            K_BNE:   word = b_type_word(imm, rs2, rs1, 3'b001);
            default: word = j_type_word(imm, rd);
        endcase
        p_kind[prog_len] = k;
        p_rd[prog_len]   = rd;
        p_rs1[prog_len]  = rs1;
        p_rs2[prog_len]  = rs2;
        p_imm[prog_len]  = imm;
        mem[CODE_WORD + prog_len] = word;
        prog_len++;
    endtask

    // sources often reuse recent destinations to hit in-flight results
    task automatic note_dest(input int rd);
        recent[3] = recent[2];
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = rd;
    endtask

    function automatic int pick_source();
        if ($urandom_range(0, 1) == 1) begin
            return recent[$urandom_range(0, 3)];
        end
        return $urandom_range(0, 31);
    endfunction

    function automatic logic [31:0] data_slot();
        return DATA_BASE + 32'(4 * $urandom_range(0, DATA_WORDS - 1));
    endfunction

    // forward by 1 to 4 words and never past the start of the dump block
    function automatic logic [31:0] forward_offset();
        int k;
        k = $urandom_range(1, 4);
        if (k > body_end - prog_len) begin
            k = body_end - prog_len;
        end
        return 32'(4 * k);
    endfunction

    task automatic build_program();
        int    n;
        int    r;
        int    choice;
        int    rd;
        int    rs1;
        int    rs2;
        kind_e k;
        for (r = 0; r < 4; r++) begin
            recent[r] = r + 1;
        end
        for (r = 1; r < 32; r++) begin
            emit(K_LUI, r, 0, 0, $urandom() & 32'hFFFF_F000);
            emit(K_ADDI, r, r, 0, sign_extend12(12'($urandom())));
            note_dest(r);
        end
        body_end = prog_len + BODY_LEN;
        for (n = 0; n < BODY_LEN; n++) begin
            choice = $urandom_range(0, 99);
            rd     = $urandom_range(1, 31);
            rs1    = pick_source();
            rs2    = pick_source();
            if (choice < 40) begin
                case ($urandom_range(0, 5))
                    0:       k = K_ADD;
                    1:       k = K_SUB;
                    2:       k = K_AND;
                    3:       k = K_OR;
                    4:       k = K_XOR;
                    default: k = K_SLT;
                endcase
                emit(k, rd, rs1, rs2, 32'd0);
                note_dest(rd);
            end else if (choice < 55) begin
                emit(K_ADDI, rd, rs1, 0, sign_extend12(12'($urandom())));
                note_dest(rd);
            end else if (choice < 62) begin
                emit(K_LUI, rd, 0, 0, $urandom() & 32'hFFFF_F000);
                note_dest(rd);
            end else if (choice < 74) begin
                emit(K_LW, rd, 0, 0, data_slot());
                note_dest(rd);
            end else if (choice < 84) begin
                emit(K_SW, 0, 0, rs2, data_slot());
            end else if (choice < 94) begin
                // equal operands now and then so beq is taken too
                if ($urandom_range(0, 3) == 0) begin
                    rs2 = rs1;
                end
                k = ($urandom_range(0, 1) == 0) ? K_BEQ : K_BNE;
                emit(k, 0, rs1, rs2, forward_offset());
            end else begin
                emit(K_JAL, rd, 0, 0, forward_offset());
                note_dest(rd);
            end
        end
        for (r = 1; r < 32; r++) begin
            emit(K_SW, 0, 0, r, DUMP_BASE + 32'(4 * (r - 1)));
        end
        halt_idx = prog_len;
        halt_pc  = RESET_PC + 32'(4 * halt_idx);
        emit(K_JAL, 0, 0, 0, 32'd0);
    endtask

    // in-order reference model that records every store
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        bit          wr;
        int          idx;
        int          next;
        int          r;
        for (r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        idx = 0;
        while (idx < halt_idx) begin
            a    = regs[p_rs1[idx]];
            b    = regs[p_rs2[idx]];
            res  = '0;
            wr   = 1'b1;
            next = idx + 1;
            case (p_kind[idx])
                K_LUI:  res = p_imm[idx];
                K_ADDI: res = a + p_imm[idx];
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_LW: begin
                    addr = a + p_imm[idx];
                    res  = model_mem[addr[11:2]];
                end
                K_SW: begin
                    wr   = 1'b0;
                    addr = a + p_imm[idx];
                    model_mem[addr[11:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (p_kind[idx] == K_BEQ)) begin
                        next = idx + int'(p_imm[idx] >> 2);
                    end
                end
                default: begin
                    res  = RESET_PC + 32'(4 * idx) + 32'd4;
                    next = idx + int'(p_imm[idx] >> 2);
                end
            endcase
            if (wr && p_rd[idx] != 0) begin
                regs[p_rd[idx]] = res;
            end
            idx = next;
        end
    endtask

    task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
        if (got_stores >= exp_addr.size()) begin
            errors++;
            $display("unexpected store at %0t to %h, the model makes only %0d stores",
                     $time, addr, exp_addr.size());
        end else begin
            check_value("mem_req_o.addr", addr, exp_addr[got_stores]);
            check_value("mem_req_o.wdata", data, exp_data[got_stores]);
        end
        got_stores++;
    endtask

    // returns last cycle's read and then samples the request on each falling edge
    task automatic serve_memory();
        logic [31:0] addr;
        if (read_pending) begin
            mem_rdata = mem[read_addr[11:2]];
        end else begin
            mem_rdata = '0;
        end
        read_pending = 1'b0;
        #1;
        addr = mem_req.addr;
        if (!rst_n_i) begin
            if (mem_req.valid) begin
                errors++;
                $display("memory request is valid while reset is asserted at %0t", $time);
            end
        end else if (mem_req.valid) begin
            if (!seen_first_req) begin
                seen_first_req = 1'b1;
                check_value("mem_req_o.we", 32'(mem_req.we), 32'd0);
                check_value("mem_req_o.addr", addr, RESET_PC);
            end
            if (addr >= 32'(MEM_WORDS * 4) || addr[1:0] != 2'b00) begin
                errors++;
                $display("access at %0t to %h is outside memory or unaligned", $time, addr);
            end else if (mem_req.we) begin
                record_store(addr, mem_req.wdata);
                mem[addr[11:2]] = mem_req.wdata;
            end else begin
                read_pending = 1'b1;
                read_addr    = addr;
                if (addr == halt_pc) begin
                    halt_fetches++;
                end
            end
        end
    endtask

    initial begin
        int unused_seed;
        int cycles;
        int i;
        rst_n_i     = 1'b0;
        mem_rdata   = '0;
        unused_seed = $urandom(40);
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hC0DE_0000 | 32'(i);
        end
        for (i = 0; i < DATA_WORDS; i++) begin
            mem[DATA_BASE[11:2] + i] = $urandom();
        end
        build_program();
        for (i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = mem[i];
        end
        run_model();

        @(negedge clk);
        serve_memory();
        @(negedge clk);
        rst_n_i = 1'b1;
        serve_memory();

        cycles = 0;
        while (halt_fetches < 2 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            serve_memory();
            cycles++;
        end
        if (halt_fetches < 2) begin
            errors++;
            $display("timeout: the halt address was not fetched twice in %0d cycles",
                     TIMEOUT_CYCLES);
        end else begin
            // a few more cycles to catch stray stores
            repeat (8) begin
                @(negedge clk);
                serve_memory();
            end
            check_value("store count", 32'(got_stores), 32'(exp_addr.size()));
        end

        $display("errors: %0d, stores: %0d of %0d, halt fetches: %0d",
                 errors, got_stores, exp_addr.size(), halt_fetches);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/exu.sv
`timescale 1ns/1ps

module exu (
    input  rv_core_pkg::dec_s      dec_i,
    input  logic                   dec_valid_i,
    output rv_core_pkg::wb_s       ex_wb_o,
    output rv_core_pkg::redirect_s redirect_o
);

    rv_core_pkg::word_t alu_res;
    rv_core_pkg::addr_t link_pc;
    logic               slt_res;
    logic               br_taken;

    assign slt_res = $signed(dec_i.op1) < $signed(dec_i.op2);

    always_comb begin
        case (dec_i.alu_op)
            rv_core_pkg::ALU_SUB:    alu_res = dec_i.op1 - dec_i.op2;
            rv_core_pkg::ALU_AND:    alu_res = dec_i.op1 & dec_i.op2;
            rv_core_pkg::ALU_OR:     alu_res = dec_i.op1 | dec_i.op2;
            rv_core_pkg::ALU_XOR:    alu_res = dec_i.op1 ^ dec_i.op2;
            rv_core_pkg::ALU_SLT:    alu_res = {31'b0, slt_res};
            rv_core_pkg::ALU_PASS_B: alu_res = dec_i.op2;
            default:                 alu_res = dec_i.op1 + dec_i.op2;
        endcase
    end

    assign link_pc = dec_i.pc + 32'd4;

    // beq when equal, bne when not
    assign br_taken = dec_i.is_branch && ((dec_i.op1 == dec_i.op2) != dec_i.branch_ne);

    assign redirect_o = '{
        valid:  dec_valid_i && (br_taken || dec_i.is_jal),
        target: dec_i.pc + dec_i.imm
    };

    // loads write back from the lsu a cycle later
    assign ex_wb_o = '{
        we:   dec_valid_i && dec_i.rd_we && !dec_i.is_load,
        rd:   dec_i.rd,
        data: dec_i.is_jal ? link_pc : alu_res
    };

endmodule

//--- rtl/idu.sv
`timescale 1ns/1ps

module idu (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_core_pkg::fetch_s   fetch_i,
    input  logic                  fetch_valid_i,
    output rv_isa_pkg::reg_addr_t rs1_addr_o,
    output rv_isa_pkg::reg_addr_t rs2_addr_o,
    input  rv_core_pkg::word_t    rs1_data_i,
    input  rv_core_pkg::word_t    rs2_data_i,
    input  rv_core_pkg::wb_s      ex_wb_i,
    input  rv_core_pkg::wb_s      ld_wb_i,
    input  logic                  flush_i,
    output logic                  stall_o,
    output rv_core_pkg::dec_s     dec_o,
    output logic                  dec_valid_o
);

    rv_isa_pkg::inst_t    inst;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::imm_e     imm_kind;
    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::word_t   imm;
    rv_core_pkg::word_t   rs1_val;
    rv_core_pkg::word_t   rs2_val;
    rv_core_pkg::dec_s    dec_d;
    rv_core_pkg::dec_s    dec_q;
    logic                 legal;
    logic                 writes_rd;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 imm_op2;
    logic                 is_load;
    logic                 is_store;
    logic                 is_branch;
    logic                 is_jal;
    logic                 dec_valid_q;

    // execute result first, then the returning load, then the regfile
    function automatic rv_core_pkg::word_t fwd(
        input rv_isa_pkg::reg_addr_t addr,
        input rv_core_pkg::word_t    rf_data,
        input rv_core_pkg::wb_s      ex_wb,
        input rv_core_pkg::wb_s      ld_wb
    );
        return (ex_wb.we && ex_wb.rd == addr) ? ex_wb.data :
               (ld_wb.we && ld_wb.rd == addr) ? ld_wb.data : rf_data;
    endfunction

    assign inst       = fetch_i.inst;
    assign funct3     = inst[14:12];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    always_comb begin
        legal     = 1'b1;
        writes_rd = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        imm_op2   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        imm_kind  = rv_isa_pkg::IMM_I;
        alu_op    = rv_core_pkg::ALU_ADD;
        case (inst[6:0])
            rv_isa_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                legal     = (inst[31:25] == '0) ||
                            (inst[31:25] == rv_isa_pkg::FUNCT7_SUB &&
                             funct3 == rv_isa_pkg::FUNCT3_ADD);
                case (funct3)
                    rv_isa_pkg::FUNCT3_ADD: begin
                        if (inst[31:25] == rv_isa_pkg::FUNCT7_SUB) begin
                            alu_op = rv_core_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::FUNCT3_SLT: alu_op = rv_core_pkg::ALU_SLT;
                    rv_isa_pkg::FUNCT3_XOR: alu_op = rv_core_pkg::ALU_XOR;
                    rv_isa_pkg::FUNCT3_OR:  alu_op = rv_core_pkg::ALU_OR;
                    rv_isa_pkg::FUNCT3_AND: alu_op = rv_core_pkg::ALU_AND;
                    default:                legal  = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // only addi
                legal     = (funct3 == rv_isa_pkg::FUNCT3_ADD);
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
                imm_op2   = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                writes_rd = 1'b1;
                imm_op2   = 1'b1;
                imm_kind  = rv_isa_pkg::IMM_U;
                alu_op    = rv_core_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OPC_LOAD: begin
                legal     = (funct3 == rv_isa_pkg::FUNCT3_LW);
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
                is_load   = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                legal    = (funct3 == rv_isa_pkg::FUNCT3_SW);
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                imm_kind = rv_isa_pkg::IMM_S;
                is_store = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                legal     = (funct3 == rv_isa_pkg::FUNCT3_BEQ) ||
                            (funct3 == rv_isa_pkg::FUNCT3_BNE);
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                imm_kind  = rv_isa_pkg::IMM_B;
                is_branch = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                imm_kind  = rv_isa_pkg::IMM_J;
                is_jal    = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        case (imm_kind)
            rv_isa_pkg::IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_isa_pkg::IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                      inst[11:8], 1'b0};
            rv_isa_pkg::IMM_U: imm = {inst[31:12], 12'b0};
            rv_isa_pkg::IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                      inst[30:21], 1'b0};
            default:           imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    assign rs1_val = fwd(rs1_addr_o, rs1_data_i, ex_wb_i, ld_wb_i);
    assign rs2_val = fwd(rs2_addr_o, rs2_data_i, ex_wb_i, ld_wb_i);

    assign dec_d = '{
        pc:        fetch_i.pc,
        op1:       rs1_val,
        op2:       imm_op2 ? imm : rs2_val,
        imm:       imm,
        rd:        inst[11:7],
        rd_we:     writes_rd && (inst[11:7] != '0),
        alu_op:    alu_op,
        is_load:   is_load,
        is_store:  is_store,
        is_branch: is_branch,
        is_jal:    is_jal,
        branch_ne: (funct3 == rv_isa_pkg::FUNCT3_BNE)
    };

    // load in execute, its data arrives one cycle too late
    assign stall_o = fetch_valid_i && legal && dec_valid_q && dec_q.is_load && dec_q.rd_we &&
                     ((use_rs1 && rs1_addr_o == dec_q.rd) ||
                      (use_rs2 && rs2_addr_o == dec_q.rd));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= fetch_valid_i && legal && !stall_o && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        dec_q <= dec_d;
    end

    assign dec_o       = dec_q;
    assign dec_valid_o = dec_valid_q;

endmodule

//--- rtl/ifu.sv
`timescale 1ns/1ps

module ifu #(
    parameter rv_core_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stall_i,
    input  rv_core_pkg::redirect_s redirect_i,
    output rv_core_pkg::mem_req_s  fetch_req_o,
    input  logic                   fetch_gnt_i,
    input  rv_core_pkg::word_t     fetch_rdata_i,
    output rv_core_pkg::fetch_s    fetch_o,
    output logic                   fetch_valid_o
);

    rv_core_pkg::addr_t pc_q;
    rv_core_pkg::addr_t fetch_pc_q;
    rv_isa_pkg::inst_t  inst_q;
    logic               run_q;
    logic               fetch_valid_q;
    logic               rdata_fresh_q;
    logic               fetch_taken;

    assign fetch_req_o = '{valid: run_q & ~stall_i, we: 1'b0, addr: pc_q, wdata: '0};
    assign fetch_taken = fetch_req_o.valid & fetch_gnt_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            run_q         <= 1'b0;
            fetch_valid_q <= 1'b0;
            rdata_fresh_q <= 1'b0;
        end else begin
            run_q         <= 1'b1;
            rdata_fresh_q <= fetch_taken;
            if (redirect_i.valid) begin
                pc_q          <= redirect_i.target;
                fetch_valid_q <= 1'b0;
            end else if (!stall_i) begin
                if (fetch_taken) begin
                    pc_q <= pc_q + 32'd4;
                end
                // a lost fetch leaves a bubble and retries the same pc
                fetch_valid_q <= fetch_taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            fetch_pc_q <= pc_q;
        end
        // keep the word in case decode holds it past this cycle
        if (rdata_fresh_q) begin
            inst_q <= fetch_rdata_i;
        end
    end

    assign fetch_o       = '{pc: fetch_pc_q, inst: rdata_fresh_q ? fetch_rdata_i : inst_q};
    assign fetch_valid_o = fetch_valid_q;

endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_core_pkg::dec_s     dec_i,
    input  logic                  dec_valid_i,
    output rv_core_pkg::mem_req_s ls_req_o,
    input  rv_core_pkg::word_t    ls_rdata_i,
    output rv_core_pkg::wb_s      ld_wb_o
);

    rv_isa_pkg::reg_addr_t ld_rd_q;
    logic                  ld_pend_q;

    assign ls_req_o = '{
        valid: dec_valid_i && (dec_i.is_load || dec_i.is_store),
        we:    dec_i.is_store,
        addr:  dec_i.op1 + dec_i.imm,
        wdata: dec_i.op2
    };

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ld_pend_q <= 1'b0;
        end else begin
            ld_pend_q <= dec_valid_i && dec_i.is_load && dec_i.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        ld_rd_q <= dec_i.rd;
    end

    // read data comes back the cycle after the request
    assign ld_wb_o = '{we: ld_pend_q, rd: ld_rd_q, data: ls_rdata_i};

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rv_core_pkg::mem_req_s fetch_req_i,
    input  rv_core_pkg::mem_req_s ls_req_i,
    output logic                  fetch_gnt_o,
    output rv_core_pkg::mem_req_s mem_req_o,
    input  rv_core_pkg::word_t    mem_rdata_i,
    output rv_core_pkg::word_t    fetch_rdata_o,
    output rv_core_pkg::word_t    ls_rdata_o
);

    // set when the outstanding read belongs to load/store
    logic ls_owner_q;

    // load/store always wins the port
    assign fetch_gnt_o = fetch_req_i.valid && !ls_req_i.valid;
    assign mem_req_o   = ls_req_i.valid ? ls_req_i : fetch_req_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ls_owner_q <= 1'b0;
        end else begin
            ls_owner_q <= ls_req_i.valid && !ls_req_i.we;
        end
    end

    assign ls_rdata_o    = ls_owner_q ? mem_rdata_i : '0;
    assign fetch_rdata_o = ls_owner_q ? '0 : mem_rdata_i;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t rs2_addr_i,
    output rv_core_pkg::word_t    rs1_data_o,
    output rv_core_pkg::word_t    rs2_data_o,
    input  rv_core_pkg::wb_s      ex_wb_i,
    input  rv_core_pkg::wb_s      ld_wb_i
);

    // x0 is not stored
    rv_core_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (ld_wb_i.we) begin
            regs[ld_wb_i.rd] <= ld_wb_i.data;
        end
        // younger instruction wins on the same rd
        if (ex_wb_i.we) begin
            regs[ex_wb_i.rd] <= ex_wb_i.data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

    typedef logic [rv_isa_pkg::XLEN-1:0] word_t;
    typedef logic [31:0]                 addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        addr_t             pc;
        rv_isa_pkg::inst_t inst;
    } fetch_s;

    // op2 already holds the immediate for OP_IMM and LUI
    typedef struct packed {
        addr_t                 pc;
        word_t                 op1;
        word_t                 op2;
        word_t                 imm;
        rv_isa_pkg::reg_addr_t rd;
        logic                  rd_we;
        alu_op_e               alu_op;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic                  branch_ne;
    } dec_s;

    typedef struct packed {
        logic                  we;
        rv_isa_pkg::reg_addr_t rd;
        word_t                 data;
    } wb_s;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_s;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_s;

endpackage

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN   = 32;
    localparam int ILEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [ILEN-1:0]   inst_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [6:0]        funct7_t;

    // major opcodes in use, anything else is a no-op
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    localparam funct3_t FUNCT3_ADD = 3'b000;
    localparam funct3_t FUNCT3_SLT = 3'b010;
    localparam funct3_t FUNCT3_XOR = 3'b100;
    localparam funct3_t FUNCT3_OR  = 3'b110;
    localparam funct3_t FUNCT3_AND = 3'b111;
    localparam funct3_t FUNCT3_LW  = 3'b010;
    localparam funct3_t FUNCT3_SW  = 3'b010;
    localparam funct3_t FUNCT3_BEQ = 3'b000;
    localparam funct3_t FUNCT3_BNE = 3'b001;

    localparam funct7_t FUNCT7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_e;

endpackage

//--- rtl/tinyrv_top.sv
`timescale 1ns/1ps

module tinyrv_top #(
    parameter rv_core_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    output rv_core_pkg::mem_req_s mem_req_o,
    input  rv_core_pkg::word_t    mem_rdata_i
);

    // fetch side
    rv_core_pkg::mem_req_s  if_fetch_req;
    rv_core_pkg::fetch_s    if_fetch;
    logic                   if_fetch_valid;
    logic                   arb_fetch_gnt;
    rv_core_pkg::word_t     arb_fetch_rdata;

    // decode and register read
    rv_isa_pkg::reg_addr_t  id_rs1_addr;
    rv_isa_pkg::reg_addr_t  id_rs2_addr;
    rv_core_pkg::word_t     rf_rs1_data;
    rv_core_pkg::word_t     rf_rs2_data;
    logic                   id_stall;
    rv_core_pkg::dec_s      id_dec;
    logic                   id_dec_valid;

    // execute and load/store
    rv_core_pkg::wb_s       ex_wb;
    rv_core_pkg::redirect_s ex_redirect;
    rv_core_pkg::mem_req_s  ls_req;
    rv_core_pkg::word_t     arb_ls_rdata;
    rv_core_pkg::wb_s       ls_wb;

    ifu #(
        .RESET_PC(RESET_PC)
    ) u_ifu (
        .clk(clk),
        .rst_n_i(rst_n_i),

        .stall_i(id_stall),
        .redirect_i(ex_redirect),

        .fetch_req_o(if_fetch_req),
        .fetch_gnt_i(arb_fetch_gnt),
        .fetch_rdata_i(arb_fetch_rdata),

        .fetch_o(if_fetch),
        .fetch_valid_o(if_fetch_valid)
    );

    idu u_idu (
        .clk(clk),
        .rst_n_i(rst_n_i),

        .fetch_i(if_fetch),
        .fetch_valid_i(if_fetch_valid),

        .rs1_addr_o(id_rs1_addr),
        .rs2_addr_o(id_rs2_addr),
        .rs1_data_i(rf_rs1_data),
        .rs2_data_i(rf_rs2_data),

        .ex_wb_i(ex_wb),
        .ld_wb_i(ls_wb),

        .flush_i(ex_redirect.valid),
        .stall_o(id_stall),

        .dec_o(id_dec),
        .dec_valid_o(id_dec_valid)
    );

    exu u_exu (
        .dec_i(id_dec),
        .dec_valid_i(id_dec_valid),
        .ex_wb_o(ex_wb),
        .redirect_o(ex_redirect)
    );

    lsu u_lsu (
        .clk(clk),
        .rst_n_i(rst_n_i),

        .dec_i(id_dec),
        .dec_valid_i(id_dec_valid),

        .ls_req_o(ls_req),
        .ls_rdata_i(arb_ls_rdata),
        .ld_wb_o(ls_wb)
    );

    regfile u_regfile (
        .clk(clk),

        .rs1_addr_i(id_rs1_addr),
        .rs2_addr_i(id_rs2_addr),
        .rs1_data_o(rf_rs1_data),
        .rs2_data_o(rf_rs2_data),

        .ex_wb_i(ex_wb),
        .ld_wb_i(ls_wb)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk),
        .rst_n_i(rst_n_i),

        .fetch_req_i(if_fetch_req),
        .ls_req_i(ls_req),
        .fetch_gnt_o(arb_fetch_gnt),

        .mem_req_o(mem_req_o),
        .mem_rdata_i(mem_rdata_i),

        .fetch_rdata_o(arb_fetch_rdata),
        .ls_rdata_o(arb_ls_rdata)
    );

endmodule

//--- tinyrv.f
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/lsu.sv
rtl/regfile.sv
rtl/mem_arbiter.sv
rtl/tinyrv_top.sv
dv/tb_tinyrv.sv
